//--- src/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// datapath and address width
`define EX_XLEN 32

// register index width
`define EX_REG_AW 5

// bytes per word, also the store strobe width
`define EX_LANES 4

// link increment for jal / jalr
`define EX_PC_STEP 4

`endif

//--- src/rv_isa_pkg.sv
`include "ex_cfg.svh"

package rv_isa_pkg;

	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111
	} opcode_e;

	// integer op codes, the other groups reuse the same values
	typedef enum logic [2:0] {
		F3_ADD  = 3'b000,
		F3_SLL  = 3'b001,
		F3_SLT  = 3'b010,
		F3_SLTU = 3'b011,
		F3_XOR  = 3'b100,
		F3_SR   = 3'b101,
		F3_OR   = 3'b110,
		F3_AND  = 3'b111
	} funct3_e;

	localparam funct3_e F3_BEQ    = funct3_e'(3'b000);
	localparam funct3_e F3_BNE    = funct3_e'(3'b001);
	localparam funct3_e F3_BLT    = funct3_e'(3'b100);
	localparam funct3_e F3_BGE    = funct3_e'(3'b101);
	localparam funct3_e F3_BLTU   = funct3_e'(3'b110);
	localparam funct3_e F3_BGEU   = funct3_e'(3'b111);
	localparam funct3_e F3_LB     = funct3_e'(3'b000);
	localparam funct3_e F3_LH     = funct3_e'(3'b001);
	localparam funct3_e F3_LW     = funct3_e'(3'b010);
	localparam funct3_e F3_LBU    = funct3_e'(3'b100);
	localparam funct3_e F3_LHU    = funct3_e'(3'b101);
	localparam funct3_e F3_SB     = funct3_e'(3'b000);
	localparam funct3_e F3_SH     = funct3_e'(3'b001);
	localparam funct3_e F3_SW     = funct3_e'(3'b010);
	localparam funct3_e F3_MUL    = funct3_e'(3'b000);
	localparam funct3_e F3_MULH   = funct3_e'(3'b001);
	localparam funct3_e F3_MULHSU = funct3_e'(3'b010);
	localparam funct3_e F3_MULHU  = funct3_e'(3'b011);
	localparam funct3_e F3_JALR   = funct3_e'(3'b000);

	localparam logic [6:0] F7_BASE   = 7'b0000000;
	localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	typedef struct packed {
		logic [6:0]            funct7;
		logic [`EX_REG_AW-1:0] rs2;
		logic [`EX_REG_AW-1:0] rs1;
		funct3_e               funct3;
		logic [`EX_REG_AW-1:0] rd;
		opcode_e               opcode;
	} inst_fields_t;

endpackage

//--- src/ex_stage_pkg.sv
`include "ex_cfg.svh"

package ex_stage_pkg;

	typedef struct packed {
		logic                valid;
		logic [31:0]         inst;
		logic [`EX_XLEN-1:0] pc;
		logic [`EX_XLEN-1:0] rs1_val;
		logic [`EX_XLEN-1:0] rs2_val;
		logic [`EX_XLEN-1:0] mem_rdata;
	} ex_req_t;

	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_MUL,
		CLS_LOAD,
		CLS_STORE,
		CLS_BRANCH,
		CLS_JUMP,
		CLS_NONE
	} op_class_e;

	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, PASS_B, PC_ADD
	} alu_op_e;

	typedef struct packed {
		op_class_e             cls;
		alu_op_e               alu_op;
		rv_isa_pkg::funct3_e   funct3;
		logic [`EX_XLEN-1:0]   pc; // branch target and link base
		logic [`EX_XLEN-1:0]   op_a;
		logic [`EX_XLEN-1:0]   op_b;
		logic [`EX_XLEN-1:0]   imm;
		logic [`EX_REG_AW-1:0] rd;
		logic                  rd_wen;
	} dec_op_t;

	typedef struct packed {
		logic                  wen;
		logic [`EX_REG_AW-1:0] rd;
		logic [`EX_XLEN-1:0]   data;
	} wb_t;

	typedef struct packed {
		logic [`EX_LANES-1:0] wstrb;
		logic [`EX_XLEN-1:0]  addr;
		logic [`EX_XLEN-1:0]  wdata;
	} store_t;

	typedef struct packed {
		logic                jump; // also flushes the younger instruction
		logic [`EX_XLEN-1:0] target;
	} redirect_t;

endpackage

//--- src/ex_decode.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_decode (
	input  ex_stage_pkg::ex_req_t req_i,
	output ex_stage_pkg::dec_op_t dec_o
);
	import rv_isa_pkg::*;
	import ex_stage_pkg::*;

	logic [31:0] ins;
	inst_fields_t f;
	logic [`EX_XLEN-1:0] imm_i;
	logic [`EX_XLEN-1:0] imm_s;
	logic [`EX_XLEN-1:0] imm_b;
	logic [`EX_XLEN-1:0] imm_u;
	logic [`EX_XLEN-1:0] imm_j;
	logic use_pc;  // op_a from pc
	logic use_imm; // op_b from imm

	// shared by op-imm and op, sub only exists in the register form
	function automatic alu_op_e f3_to_alu(input funct3_e f3, input logic sub, input logic arith);
		alu_op_e op;
		case (f3)
			F3_ADD:  op = sub ? SUB : ADD;
			F3_SLL:  op = SLL;
			F3_SLT:  op = SLT;
			F3_SLTU: op = SLTU;
			F3_XOR:  op = XOR;
			F3_SR:   op = arith ? SRA : SRL;
			F3_OR:   op = OR;
			default: op = AND;
		endcase
		return op;
	endfunction

	assign ins = req_i.inst;
	assign f = inst_fields_t'(ins);

	assign imm_i = {{(`EX_XLEN-12){ins[31]}}, ins[31:20]};
	assign imm_s = {{(`EX_XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};
	assign imm_b = {{(`EX_XLEN-13){ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
	assign imm_u = {ins[31:12], 12'b0};
	assign imm_j = {{(`EX_XLEN-21){ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

	always_comb begin
		dec_o.cls = CLS_NONE;
		dec_o.alu_op = ADD;
		dec_o.imm = imm_i;
		use_pc = 1'b0;
		use_imm = 1'b1;
		case (f.opcode)
			OP_IMM: begin
				dec_o.alu_op = f3_to_alu(f.funct3, 1'b0, ins[30]);
				if (f.funct3 == F3_SLL && f.funct7 != F7_BASE) begin
					dec_o.cls = CLS_NONE;
				end else if (f.funct3 == F3_SR && f.funct7 != F7_BASE && f.funct7 != F7_ALT) begin
					dec_o.cls = CLS_NONE;
				end else begin
					dec_o.cls = CLS_ALU;
				end
			end
			OP: begin
				use_imm = 1'b0;
				dec_o.alu_op = f3_to_alu(f.funct3, ins[30], ins[30]);
				if (f.funct7 == F7_BASE) begin
					dec_o.cls = CLS_ALU;
				end else if (f.funct7 == F7_ALT && f.funct3 inside {F3_ADD, F3_SR}) begin
					dec_o.cls = CLS_ALU;
				end else if (f.funct7 == F7_MULDIV &&
						f.funct3 inside {F3_MUL, F3_MULH, F3_MULHSU, F3_MULHU}) begin
					dec_o.cls = CLS_MUL; // div and rem fall through to none
				end
			end
			LOAD: begin
				if (f.funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU})
					dec_o.cls = CLS_LOAD;
			end
			STORE: begin
				dec_o.imm = imm_s;
				use_imm = 1'b0; // op_b carries the store data
				if (f.funct3 inside {F3_SB, F3_SH, F3_SW})
					dec_o.cls = CLS_STORE;
			end
			BRANCH: begin
				dec_o.imm = imm_b;
				use_imm = 1'b0;
				if (f.funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU})
					dec_o.cls = CLS_BRANCH;
			end
			JAL: begin
				dec_o.imm = imm_j;
				use_pc = 1'b1;
				dec_o.cls = CLS_JUMP;
			end
			JALR: begin
				if (f.funct3 == F3_JALR)
					dec_o.cls = CLS_JUMP;
			end
			LUI: begin
				dec_o.imm = imm_u;
				dec_o.alu_op = PASS_B;
				dec_o.cls = CLS_ALU;
			end
			AUIPC: begin
				dec_o.imm = imm_u;
				use_pc = 1'b1;
				dec_o.alu_op = PC_ADD;
				dec_o.cls = CLS_ALU;
			end
			default: ;
		endcase

		dec_o.funct3 = f.funct3;
		dec_o.pc = req_i.pc;
		dec_o.op_a = use_pc ? req_i.pc : req_i.rs1_val;
		dec_o.op_b = use_imm ? dec_o.imm : req_i.rs2_val;
		dec_o.rd = f.rd;
		dec_o.rd_wen = dec_o.cls inside {CLS_ALU, CLS_MUL, CLS_LOAD, CLS_JUMP};
	end

endmodule

//--- src/ex_alu.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_alu (
	input  ex_stage_pkg::dec_op_t dec_i,
	output logic [`EX_XLEN-1:0]   res_o
);
	import ex_stage_pkg::*;

	localparam int SHW = $clog2(`EX_XLEN);

	logic [`EX_XLEN-1:0] a;
	logic [`EX_XLEN-1:0] b;
	logic [SHW-1:0] shamt;
	logic lt;
	logic ltu;

	assign a = dec_i.op_a;
	assign b = dec_i.op_b;
	assign shamt = b[SHW-1:0];
	assign lt = $signed(a) < $signed(b);
	assign ltu = a < b;

	always_comb begin
		case (dec_i.alu_op)
			ADD, PC_ADD: res_o = a + b; // auipc already has pc in op_a
			SUB:         res_o = a - b;
			AND:         res_o = a & b;
			OR:          res_o = a | b;
			XOR:         res_o = a ^ b;
			SLL:         res_o = a << shamt;
			SRL:         res_o = a >> shamt;
			SRA:         res_o = $signed(a) >>> shamt;
			SLT:         res_o = {{(`EX_XLEN-1){1'b0}}, lt};
			SLTU:        res_o = {{(`EX_XLEN-1){1'b0}}, ltu};
			PASS_B:      res_o = b; // lui
			default:     res_o = '0;
		endcase
	end

endmodule

//--- src/ex_mul.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_mul (
	input  ex_stage_pkg::dec_op_t dec_i,
	output logic [`EX_XLEN-1:0]   res_o
);
	import rv_isa_pkg::*;

	logic a_neg;
	logic b_neg;
	logic [`EX_XLEN-1:0] a_mag;
	logic [`EX_XLEN-1:0] b_mag;
	logic [2*`EX_XLEN-1:0] prod;
	logic [2*`EX_XLEN-1:0] prod_s;

	// only operands read as signed contribute a sign
	assign a_neg = (dec_i.funct3 inside {F3_MULH, F3_MULHSU}) & dec_i.op_a[`EX_XLEN-1];
	assign b_neg = (dec_i.funct3 == F3_MULH) & dec_i.op_b[`EX_XLEN-1];

	assign a_mag = a_neg ? -dec_i.op_a : dec_i.op_a;
	assign b_mag = b_neg ? -dec_i.op_b : dec_i.op_b;

	assign prod = {{`EX_XLEN{1'b0}}, a_mag} * {{`EX_XLEN{1'b0}}, b_mag};
	assign prod_s = (a_neg ^ b_neg) ? -prod : prod;

	// low half is sign independent
	assign res_o = (dec_i.funct3 == F3_MUL) ? prod_s[`EX_XLEN-1:0]
		: prod_s[2*`EX_XLEN-1:`EX_XLEN];

endmodule

//--- src/ex_branch.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_branch (
	input  ex_stage_pkg::dec_op_t   dec_i,
	output ex_stage_pkg::redirect_t redir_o,
	output logic [`EX_XLEN-1:0]     link_o
);
	import rv_isa_pkg::*;
	import ex_stage_pkg::*;

	logic eq;
	logic lt;
	logic ltu;
	logic [`EX_XLEN-1:0] jump_sum;

	assign eq = dec_i.op_a == dec_i.op_b;
	assign lt = $signed(dec_i.op_a) < $signed(dec_i.op_b);
	assign ltu = dec_i.op_a < dec_i.op_b;

	// op_a is pc for jal and rs1 for jalr
	assign jump_sum = dec_i.op_a + dec_i.imm;

	assign link_o = dec_i.pc + `EX_PC_STEP;

	always_comb begin
		redir_o.jump = 1'b0;
		redir_o.target = dec_i.pc + dec_i.imm;
		case (dec_i.cls)
			CLS_BRANCH: begin
				case (dec_i.funct3)
					F3_BEQ:  redir_o.jump = eq;
					F3_BNE:  redir_o.jump = ~eq;
					F3_BLT:  redir_o.jump = lt;
					F3_BGE:  redir_o.jump = ~lt;
					F3_BLTU: redir_o.jump = ltu;
					F3_BGEU: redir_o.jump = ~ltu;
					default: redir_o.jump = 1'b0;
				endcase
			end
			CLS_JUMP: begin
				redir_o.jump = 1'b1;
				redir_o.target = {jump_sum[`EX_XLEN-1:1], 1'b0}; // jal sum is even anyway
			end
			default: ;
		endcase
	end

endmodule

//--- src/ex_lsu.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_lsu (
	input  ex_stage_pkg::dec_op_t dec_i,
	input  logic [`EX_XLEN-1:0]   rdata_i,
	output ex_stage_pkg::store_t  store_o,
	output logic [`EX_XLEN-1:0]   load_o
);
	import rv_isa_pkg::*;

	localparam int OFF_W = $clog2(`EX_LANES);
	localparam logic [`EX_LANES-1:0] STRB_BYTE = 1;
	localparam logic [`EX_LANES-1:0] STRB_HALF = 3;

	logic [`EX_XLEN-1:0] addr;
	logic [OFF_W-1:0] off;
	logic [OFF_W-1:0] half_off;
	logic [`EX_XLEN-1:0] byte_lane;
	logic [`EX_XLEN-1:0] half_lane;

	assign addr = dec_i.op_a + dec_i.imm;
	assign off = addr[OFF_W-1:0];
	assign half_off = {off[OFF_W-1:1], 1'b0}; // halfword aligned lane

	always_comb begin
		store_o.addr = addr;
		store_o.wstrb = '0;
		store_o.wdata = '0;
		case (dec_i.funct3)
			F3_SW: begin
				store_o.wstrb = '1;
				store_o.wdata = dec_i.op_b;
			end
			F3_SH: begin
				store_o.wstrb = STRB_HALF << half_off;
				store_o.wdata = {{(`EX_XLEN-16){1'b0}}, dec_i.op_b[15:0]} << {half_off, 3'b000};
			end
			F3_SB: begin
				store_o.wstrb = STRB_BYTE << off;
				store_o.wdata = {{(`EX_XLEN-8){1'b0}}, dec_i.op_b[7:0]} << {off, 3'b000};
			end
			default: ;
		endcase
	end

	// selected lane moved down to bit 0
	assign byte_lane = rdata_i >> {off, 3'b000};
	assign half_lane = rdata_i >> {half_off, 3'b000};

	always_comb begin
		case (dec_i.funct3)
			F3_LB:   load_o = {{(`EX_XLEN-8){byte_lane[7]}}, byte_lane[7:0]};
			F3_LH:   load_o = {{(`EX_XLEN-16){half_lane[15]}}, half_lane[15:0]};
			F3_LW:   load_o = rdata_i;
			F3_LBU:  load_o = {{(`EX_XLEN-8){1'b0}}, byte_lane[7:0]};
			F3_LHU:  load_o = {{(`EX_XLEN-16){1'b0}}, half_lane[15:0]};
			default: load_o = '0;
		endcase
	end

endmodule

//--- src/ex_commit.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_commit (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    valid_i,
	input  ex_stage_pkg::dec_op_t   dec_i,
	input  logic [`EX_XLEN-1:0]     alu_i,
	input  logic [`EX_XLEN-1:0]     mul_i,
	input  logic [`EX_XLEN-1:0]     load_i,
	input  logic [`EX_XLEN-1:0]     link_i,
	input  ex_stage_pkg::store_t    store_i,
	input  ex_stage_pkg::redirect_t redir_i,
	output ex_stage_pkg::wb_t       wb_o,
	output ex_stage_pkg::store_t    store_o,
	output ex_stage_pkg::redirect_t redirect_o
);
	import ex_stage_pkg::*;

	wb_t wb_d;
	store_t store_d;
	redirect_t redir_d;

	always_comb begin
		case (dec_i.cls)
			CLS_ALU:  wb_d.data = alu_i;
			CLS_MUL:  wb_d.data = mul_i;
			CLS_LOAD: wb_d.data = load_i;
			CLS_JUMP: wb_d.data = link_i; // pc + 4
			default:  wb_d.data = '0;
		endcase
		wb_d.rd = dec_i.rd;
		wb_d.wen = valid_i & dec_i.rd_wen & (dec_i.rd != '0); // x0 stays zero

		store_d = store_i;
		if (!(valid_i && dec_i.cls == CLS_STORE))
			store_d.wstrb = '0;

		redir_d = redir_i;
		redir_d.jump = valid_i & redir_i.jump & (dec_i.cls inside {CLS_BRANCH, CLS_JUMP});
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_o <= '0;
			store_o <= '0;
			redirect_o <= '0;
		end else begin
			wb_o <= wb_d;
			store_o <= store_d;
			redirect_o <= redir_d;
		end
	end

endmodule

//--- src/ex_top.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_top (
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  ex_stage_pkg::ex_req_t   req_i,
	output ex_stage_pkg::wb_t       wb_o,
	output ex_stage_pkg::store_t    store_o,
	output ex_stage_pkg::redirect_t redirect_o
);
	import ex_stage_pkg::*;

	dec_op_t dec;
	logic [`EX_XLEN-1:0] alu_res;
	logic [`EX_XLEN-1:0] mul_res;
	logic [`EX_XLEN-1:0] load_res;
	logic [`EX_XLEN-1:0] link;
	store_t store_c;
	redirect_t redir_c;

	ex_decode u_decode (.req_i(req_i), .dec_o(dec));

	ex_alu u_alu (.dec_i(dec), .res_o(alu_res));

	ex_mul u_mul (.dec_i(dec), .res_o(mul_res));

	ex_branch u_branch (.dec_i(dec), .redir_o(redir_c), .link_o(link));

	ex_lsu u_lsu (.dec_i(dec), .rdata_i(req_i.mem_rdata), .store_o(store_c), .load_o(load_res));

	// only state in the stage
	ex_commit u_commit (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.valid_i    (req_i.valid),
		.dec_i      (dec),
		.alu_i      (alu_res),
		.mul_i      (mul_res),
		.load_i     (load_res),
		.link_i     (link),
		.store_i    (store_c),
		.redir_i    (redir_c),
		.wb_o       (wb_o),
		.store_o    (store_o),
		.redirect_o (redirect_o)
	);

endmodule

//--- tests/tb_ex_top.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module tb_ex_top;
	import ex_stage_pkg::*;

	localparam int MIN_LINES = 50;
	localparam int MAX_ITERS = 500; // bound on file lines read
	localparam string STIM_FILE = "tests/ex_stimulus.txt";

	logic clk;
	logic rst_n;
	ex_req_t req;
	wb_t wb;
	store_t store;
	redirect_t redir;

	integer seed;
	integer fd;
	int n_lines;
	int iters;
	int n_bub;
	int n_items;
	string line;
	logic [31:0] rnd;

	// one stimulus line
	logic [31:0] f_inst;
	logic [31:0] f_pc;
	logic [31:0] f_rs1;
	logic [31:0] f_rs2;
	logic [31:0] f_rdata;
	logic [31:0] e_wen;
	logic [31:0] e_rd;
	logic [31:0] e_data;
	logic [31:0] e_strb;
	logic [31:0] e_addr;
	logic [31:0] e_wdata;
	logic [31:0] e_jump;
	logic [31:0] e_target;
	wb_t exp_wb;
	store_t exp_st;
	redirect_t exp_redir;

	ex_top u_dut (
		.clk_i      (clk),
		.rst_n_i    (rst_n),
		.req_i      (req),
		.wb_o       (wb),
		.store_o    (store),
		.redirect_o (redir)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_failed();
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		$display("ERR @%0t: %s", $time, msg);
		stop_failed();
	endtask

	// data fields only matter when the control bit is set
	task automatic check_wb(input wb_t got, input wb_t exp, input string what);
		if (got.wen !== exp.wen || (exp.wen && (got.rd !== exp.rd || got.data !== exp.data)))
			report_mismatch($sformatf("%s: wb wen/rd/data %0b/%0d/%h, expected %0b/%0d/%h",
				what, got.wen, got.rd, got.data, exp.wen, exp.rd, exp.data));
	endtask

	task automatic check_store(input store_t got, input store_t exp, input string what);
		if (got.wstrb !== exp.wstrb ||
				(exp.wstrb != '0 && (got.addr !== exp.addr || got.wdata !== exp.wdata)))
			report_mismatch($sformatf("%s: store strb/addr/wdata %h/%h/%h, expected %h/%h/%h",
				what, got.wstrb, got.addr, got.wdata, exp.wstrb, exp.addr, exp.wdata));
	endtask

	task automatic check_redirect(input redirect_t got, input redirect_t exp, input string what);
		if (got.jump !== exp.jump || (exp.jump && got.target !== exp.target))
			report_mismatch($sformatf("%s: redirect jump/target %0b/%h, expected %0b/%h",
				what, got.jump, got.target, exp.jump, exp.target));
	endtask

	task automatic check_idle(input string what);
		check_wb(wb, wb_t'(0), what);
		check_store(store, store_t'(0), what);
		check_redirect(redir, redirect_t'(0), what);
	endtask

	task automatic step_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic apply_request(input logic [31:0] inst, input logic [31:0] pc,
			input logic [31:0] rs1, input logic [31:0] rs2, input logic [31:0] rdata);
		req.valid = 1'b1;
		req.inst = inst;
		req.pc = pc;
		req.rs1_val = rs1;
		req.rs2_val = rs2;
		req.mem_rdata = rdata;
	endtask

	task automatic apply_bubble();
		req.valid = 1'b0; // garbage fields, must not leak
		req.inst = $random(seed);
		req.pc = $random(seed);
		req.rs1_val = $random(seed);
		req.rs2_val = $random(seed);
		req.mem_rdata = $random(seed);
	endtask

	initial begin
		seed = 32'hdf36;
		n_lines = 0;
		iters = 0;
		rst_n = 1'b0;
		req = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_idle("after reset");

		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file %s", STIM_FILE);
			stop_failed();
		end

		while (!$feof(fd)) begin
			iters++;
			if (iters > MAX_ITERS) begin
				$display("Timed out: no end of the stimulus file after %0d lines", MAX_ITERS);
				stop_failed();
			end
			if ($fgets(line, fd) == 0)
				break;
			if (line.len() == 0 || line[0] == "#")
				continue; // column header
			n_items = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
				f_inst, f_pc, f_rs1, f_rs2, f_rdata, e_wen, e_rd, e_data,
				e_strb, e_addr, e_wdata, e_jump, e_target);
			if (n_items <= 0)
				continue;
			if (n_items != 13) begin
				$display("Stimulus line has %0d fields instead of 13: %s", n_items, line);
				stop_failed();
			end
			n_lines++;
			exp_wb.wen = e_wen[0];
			exp_wb.rd = e_rd[`EX_REG_AW-1:0];
			exp_wb.data = e_data;
			exp_st.wstrb = e_strb[`EX_LANES-1:0];
			exp_st.addr = e_addr;
			exp_st.wdata = e_wdata;
			exp_redir.jump = e_jump[0];
			exp_redir.target = e_target;

			apply_request(f_inst, f_pc, f_rs1, f_rs2, f_rdata);
			step_cycle();
			check_wb(wb, exp_wb, $sformatf("line %0d", n_lines));
			check_store(store, exp_st, $sformatf("line %0d", n_lines));
			check_redirect(redir, exp_redir, $sformatf("line %0d", n_lines));

			// about half the requests go back to back
			rnd = $random(seed);
			n_bub = rnd[2] ? int'(rnd[1:0]) + 1 : 0;
			repeat (n_bub) begin
				apply_bubble();
				step_cycle();
				check_idle($sformatf("bubble after line %0d", n_lines));
			end
		end
		$fclose(fd);

		if (n_lines < MIN_LINES) begin
			$display("Stimulus file too short: %0d lines, at least %0d needed",
				n_lines, MIN_LINES);
			stop_failed();
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

//--- tests/ex_stimulus.txt
# inst pc rs1 rs2 mem_rdata | wb: wen rd data | store: wstrb addr wdata | redirect: jump target
# all hex, expected fields of an inactive output are 0
002082b3 00000000 00000007 fffffffd 00000000 1 05 00000004 0 00000000 00000000 0 00000000
402082b3 00000000 00000005 00000009 00000000 1 05 fffffffc 0 00000000 00000000 0 00000000
002092b3 00000000 00000003 00000024 00000000 1 05 00000030 0 00000000 00000000 0 00000000
0020a2b3 00000000 fffffff0 00000001 00000000 1 05 00000001 0 00000000 00000000 0 00000000
0020b2b3 00000000 fffffff0 00000001 00000000 1 05 00000000 0 00000000 00000000 0 00000000
0020c2b3 00000000 f0f0f0f0 ff00ff00 00000000 1 05 0ff00ff0 0 00000000 00000000 0 00000000
0020d2b3 00000000 80000000 00000004 00000000 1 05 08000000 0 00000000 00000000 0 00000000
4020d2b3 00000000 80000000 00000004 00000000 1 05 f8000000 0 00000000 00000000 0 00000000
0020e2b3 00000000 12340000 00005678 00000000 1 05 12345678 0 00000000 00000000 0 00000000
0020f2b3 00000000 0f0f0f0f 00ff00ff 00000000 1 05 000f000f 0 00000000 00000000 0 00000000
fff08293 00000000 00000010 00000000 00000000 1 05 0000000f 0 00000000 00000000 0 00000000
0f00f293 00000000 12345678 00000000 00000000 1 05 00000070 0 00000000 00000000 0 00000000
4080d293 00000000 80001234 00000000 00000000 1 05 ff800012 0 00000000 00000000 0 00000000
ffb0a293 00000000 fffffff0 00000000 00000000 1 05 00000001 0 00000000 00000000 0 00000000
00508013 00000000 00000001 00000000 00000000 0 00 00000000 0 00000000 00000000 0 00000000
123452b7 00000000 00000000 00000000 00000000 1 05 12345000 0 00000000 00000000 0 00000000
00001297 00000100 00000000 00000000 00000000 1 05 00001100 0 00000000 00000000 0 00000000
022082b3 00000000 fffffffd 00000007 00000000 1 05 ffffffeb 0 00000000 00000000 0 00000000
022092b3 00000000 80000000 80000000 00000000 1 05 40000000 0 00000000 00000000 0 00000000
02209533 00000000 fffffffe 7fffffff 00000000 1 0a ffffffff 0 00000000 00000000 0 00000000
0220a2b3 00000000 ffffffff ffffffff 00000000 1 05 ffffffff 0 00000000 00000000 0 00000000
0220a2b3 00000000 00000002 80000000 00000000 1 05 00000001 0 00000000 00000000 0 00000000
0220b2b3 00000000 ffffffff ffffffff 00000000 1 05 fffffffe 0 00000000 00000000 0 00000000
00108283 00000000 00001000 00000000 8899aabb 1 05 ffffffaa 0 00000000 00000000 0 00000000
00308283 00000000 00001000 00000000 8899aabb 1 05 ffffff88 0 00000000 00000000 0 00000000
0030c283 00000000 00001000 00000000 8899aabb 1 05 00000088 0 00000000 00000000 0 00000000
00209283 00000000 00001000 00000000 8899aabb 1 05 ffff8899 0 00000000 00000000 0 00000000
0000d283 00000000 00001000 00000000 8899aabb 1 05 0000aabb 0 00000000 00000000 0 00000000
0020d283 00000000 00001000 00000000 8899aabb 1 05 00008899 0 00000000 00000000 0 00000000
0000a283 00000000 00001000 00000000 8899aabb 1 05 8899aabb 0 00000000 00000000 0 00000000
00208023 00000000 00002000 123456ab 00000000 0 00 00000000 1 00002000 000000ab 0 00000000
002080a3 00000000 00002000 123456ab 00000000 0 00 00000000 2 00002001 0000ab00 0 00000000
00208123 00000000 00002000 123456ab 00000000 0 00 00000000 4 00002002 00ab0000 0 00000000
002081a3 00000000 00002000 123456ab 00000000 0 00 00000000 8 00002003 ab000000 0 00000000
00209023 00000000 00002000 123456ab 00000000 0 00 00000000 3 00002000 000056ab 0 00000000
00209123 00000000 00002000 123456ab 00000000 0 00 00000000 c 00002002 56ab0000 0 00000000
fe20ae23 00000000 00002004 123456ab 00000000 0 00 00000000 f 00002000 123456ab 0 00000000
00208863 00000200 00000005 00000005 00000000 0 00 00000000 0 00000000 00000000 1 00000210
00208863 00000200 00000005 00000006 00000000 0 00 00000000 0 00000000 00000000 0 00000000
00209863 00000200 00000005 00000006 00000000 0 00 00000000 0 00000000 00000000 1 00000210
00209863 00000200 00000005 00000005 00000000 0 00 00000000 0 00000000 00000000 0 00000000
0020c863 00000200 ffffffff 00000001 00000000 0 00 00000000 0 00000000 00000000 1 00000210
0020c863 00000200 00000001 ffffffff 00000000 0 00 00000000 0 00000000 00000000 0 00000000
0020d863 00000200 00000001 ffffffff 00000000 0 00 00000000 0 00000000 00000000 1 00000210
0020d863 00000200 ffffffff 00000001 00000000 0 00 00000000 0 00000000 00000000 0 00000000
0020e863 00000200 00000001 ffffffff 00000000 0 00 00000000 0 00000000 00000000 1 00000210
0020e863 00000200 ffffffff 00000001 00000000 0 00 00000000 0 00000000 00000000 0 00000000
0020f863 00000200 ffffffff 00000001 00000000 0 00 00000000 0 00000000 00000000 1 00000210
0020f863 00000200 00000001 ffffffff 00000000 0 00 00000000 0 00000000 00000000 0 00000000
fe209ce3 00000300 00000001 00000002 00000000 0 00 00000000 0 00000000 00000000 1 000002f8
100000ef 00000400 00000000 00000000 00000000 1 01 00000404 0 00000000 00000000 1 00000500
ffdff2ef 00000600 00000000 00000000 00000000 1 05 00000604 0 00000000 00000000 1 000005fc
003082e7 00000700 00001000 00000000 00000000 1 05 00000704 0 00000000 00000000 1 00001002
1000006f 00000800 00000000 00000000 00000000 0 00 00000000 0 00000000 00000000 1 00000900

//--- vlog.f
+incdir+src
src/rv_isa_pkg.sv
src/ex_stage_pkg.sv
src/ex_decode.sv
src/ex_alu.sv
src/ex_mul.sv
src/ex_branch.sv
src/ex_lsu.sv
src/ex_commit.sv
src/ex_top.sv
tests/tb_ex_top.sv

//--- Makefile
TOOL   := verilator
FLAGS  := --binary --timing
TOP    := tb_ex_top
FLIST  := vlog.f
OBJDIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)
